// File: bender.yml
package:
  name: usb_tx
  authors: []

sources:
  - verilog/usb_tx_pkg.sv
  - verilog/usb_tx_pkt_if.sv
  - verilog/usb_tx_csr.sv
  - verilog/usb_tx_fifo.sv
  - verilog/usb_fs_tx.sv
  - verilog/usb_tx_top.sv
  - target: simulation
    files:
      - testbench/usb_rx_model.sv
      - testbench/tb_usb_tx.sv

// File: all.f
verilog/usb_tx_pkg.sv
verilog/usb_tx_pkt_if.sv
verilog/usb_tx_csr.sv
verilog/usb_tx_fifo.sv
verilog/usb_fs_tx.sv
verilog/usb_tx_top.sv
testbench/usb_rx_model.sv
testbench/tb_usb_tx.sv

// File: testbench/tb_usb_tx.sv
// Testbench for the USB full-speed transmitter, 8 ns clock stands in for 48 MHz
// Packets come from a table, inputs change 1 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_usb_tx import usb_tx_pkg::*; ();

  localparam int ClkPeriod  = 8;
  localparam int NumTests   = 5;
  localparam int MaxPayload = 9;
  localparam int MaxPktBits = 128;
  localparam int WatchdogNs = (NumTests + 2) * MaxPktBits * BitDiv * ClkPeriod * 4;

  logic     clk_i, rst_ni;
  logic     wb_cyc, wb_stb, wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_wdat, wb_rdat;
  logic     wb_ack;
  logic     usb_oe, usb_d, usb_se0, usb_dp, usb_dn;
  logic     flip_q, model_en;
  int       rx_pkt_cnt;
  logic     rx_run_err, rx_stuff_err, rx_align_err, rx_se0_err;
  int       err_cnt;
  logic [16:0] lfsr_q;

  // Packet table
  string     t_name [NumTests];
  usb_pid_t  t_pid  [NumTests];
  int        t_len  [NumTests];
  logic      t_flip [NumTests];
  logic      t_ovf  [NumTests];
  usb_byte_t t_data [NumTests][MaxPayload];

  usb_tx_top dut0 (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .wb_cyc_i  (wb_cyc),
    .wb_stb_i  (wb_stb),
    .wb_we_i   (wb_we),
    .wb_adr_i  (wb_adr),
    .wb_dat_i  (wb_wdat),
    .wb_dat_o  (wb_rdat),
    .wb_ack_o  (wb_ack),
    .usb_oe_o  (usb_oe),
    .usb_d_o   (usb_d),
    .usb_se0_o (usb_se0),
    .usb_dp_o  (usb_dp),
    .usb_dn_o  (usb_dn)
  );

  usb_rx_model rx0 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .en_i        (model_en),
    .pinflip_i   (flip_q),
    .oe_i        (usb_oe),
    .dp_i        (usb_dp),
    .dn_i        (usb_dn),
    .se0_i       (usb_se0),
    .pkt_cnt_o   (rx_pkt_cnt),
    .run_err_o   (rx_run_err),
    .stuff_err_o (rx_stuff_err),
    .align_err_o (rx_align_err),
    .se0_err_o   (rx_se0_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired before the test sequence finished");
    stop_failed();
  end

  task automatic stop_failed();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      err_cnt++;
      $display("[ERROR] %s: expected %0h, actual %0h", name, exp, act);
      stop_failed();
    end
  endtask

  // Fibonacci LFSR, taps 17 and 14
  function automatic logic [16:0] lfsr_step(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  task automatic rand_byte(output usb_byte_t b);
    for (int i = 0; i < 8; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      b[i]   = lfsr_q[0];
    end
  endtask

  // Reflected CRC16, the first bit on the line is the low bit of the register
  function automatic logic [15:0] crc16_ref(input int idx, input int n);
    logic [15:0] r;
    r = 16'hFFFF;
    for (int k = 0; k < n; k++) begin
      for (int j = 0; j < 8; j++) begin
        if (r[0] ^ t_data[idx][k][j]) begin
          r = (r >> 1) ^ 16'hA001;
        end else begin
          r = r >> 1;
        end
      end
    end
    return ~r;
  endfunction

  task automatic set_entry(input int i, input string name, input usb_pid_t pid, input int len,
                           input logic flip, input logic ovf, input logic rand_fill);
    t_name[i] = name;
    t_pid[i]  = pid;
    t_len[i]  = len;
    t_flip[i] = flip;
    t_ovf[i]  = ovf;
    for (int k = 0; k < MaxPayload; k++) begin
      if (rand_fill) begin
        rand_byte(t_data[i][k]);
      end else begin
        t_data[i][k] = 8'hFF;
      end
    end
  endtask

  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                           output wb_data_t rdat);
    int n;
    n = 0;
    wb_cyc  = 1'b1;
    wb_stb  = 1'b1;
    wb_we   = we;
    wb_adr  = adr;
    wb_wdat = dat;
    do begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 16) begin
        $display("Bus cycle got no acknowledge");
        stop_failed();
      end
    end while (!wb_ack);
    rdat   = wb_rdat;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  task automatic wait_oe(input logic level);
    int n;
    n = 0;
    while (usb_oe !== level) begin
      @(posedge clk_i);
      #1;
      n++;
      if (n > 1000) begin
        $display("Output enable did not reach the expected level");
        stop_failed();
      end
    end
  endtask

  task automatic wait_done();
    wb_data_t st;
    int       polls;
    polls = 0;
    do begin
      wb_read(AddrStatus, st);
      polls++;
      if (polls > 1000) begin
        $display("Done flag never came up after the PID write");
        stop_failed();
      end
    end while (!st[StDone]);
  endtask

  task automatic run_entry(input int i);
    wb_data_t  st;
    usb_byte_t exp_q[$];
    int        base, nbytes;
    logic [15:0] crc;
    flip_q = t_flip[i];
    wb_write(AddrCtrl, wb_data_t'(t_flip[i]) << CtrlPinFlip);
    repeat (2) @(posedge clk_i);
    #1;
    check_value({t_name[i], " idle dp"}, !t_flip[i], usb_dp);
    check_value({t_name[i], " idle dn"}, t_flip[i], usb_dn);
    for (int k = 0; k < t_len[i]; k++) begin
      wb_write(AddrData, wb_data_t'(t_data[i][k]));
    end
    wb_read(AddrStatus, st);
    check_value({t_name[i], " overflow"}, t_ovf[i], st[StOvf]);
    base = rx_pkt_cnt;
    wb_write(AddrPid, wb_data_t'(t_pid[i]));
    wait_done();
    wb_read(AddrStatus, st);
    check_value({t_name[i], " done after read"}, 0, st[StDone]);
    check_value({t_name[i], " busy"}, 0, st[StBusy]);
    check_value({t_name[i], " empty"}, 1, st[StEmpty]);
    check_value({t_name[i], " packet count"}, base + 1, rx_pkt_cnt);

    exp_q.push_back(8'h80);
    exp_q.push_back({~t_pid[i], t_pid[i]});
    // DATA0 and DATA1 carry payload and CRC16
    if (t_pid[i][1:0] == 2'b11) begin
      nbytes = (t_len[i] > FifoDepth) ? FifoDepth : t_len[i];
      for (int k = 0; k < nbytes; k++) begin
        exp_q.push_back(t_data[i][k]);
      end
      crc = crc16_ref(i, nbytes);
      exp_q.push_back(crc[7:0]);
      exp_q.push_back(crc[15:8]);
    end
    check_value({t_name[i], " byte count"}, exp_q.size(), rx0.pkt_bytes.size());
    foreach (exp_q[k]) begin
      check_value($sformatf("%s byte %0d", t_name[i], k), exp_q[k], rx0.pkt_bytes[k]);
    end
    check_value({t_name[i], " run of seven"}, 0, rx_run_err);
    check_value({t_name[i], " stuff bit"}, 0, rx_stuff_err);
    check_value({t_name[i], " byte align"}, 0, rx_align_err);
    check_value({t_name[i], " se0 pin"}, 0, rx_se0_err);
    wait_oe(1'b0);
    check_value({t_name[i], " end dp"}, !t_flip[i], usb_dp);
  endtask

  initial begin
    wb_data_t st;
    logic     prev;
    err_cnt  = 0;
    lfsr_q   = 17'd98151;
    rst_ni   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_wdat  = '0;
    flip_q   = 1'b0;
    model_en = 1'b1;

    set_entry(0, "token_in", 4'h9, 0, 1'b0, 1'b0, 1'b1);
    set_entry(1, "data0_empty", 4'h3, 0, 1'b0, 1'b0, 1'b1);
    set_entry(2, "data1_stuff", 4'hB, 4, 1'b1, 1'b0, 1'b0);
    set_entry(3, "data1_full", 4'hB, 8, 1'b0, 1'b0, 1'b1);
    set_entry(4, "data0_overflow", 4'h3, 9, 1'b1, 1'b1, 1'b1);

    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    check_value("reset oe", 0, usb_oe);
    check_value("reset dp", 1, usb_dp);
    check_value("reset dn", 0, usb_dn);
    check_value("reset d", 1, usb_d);
    check_value("reset se0", 0, usb_se0);
    wb_read(AddrStatus, st);
    check_value("reset empty", 1, st[StEmpty]);
    check_value("reset busy", 0, st[StBusy]);

    for (int i = 0; i < NumTests; i++) begin
      run_entry(i);
    end

    ////////////////////////////////////////////////////////////
    // Oscillator test mode
    ////////////////////////////////////////////////////////////
    model_en = 1'b0;
    flip_q   = 1'b0;
    wb_write(AddrCtrl, wb_data_t'(1) << CtrlOscTest);
    wait_oe(1'b1);
    @(negedge clk_i);
    prev = usb_dp;
    repeat (12) begin
      repeat (BitDiv) @(negedge clk_i);
      check_value("osc toggle", !prev, usb_dp);
      check_value("osc toggle d", !prev, usb_d);
      check_value("osc se0", 0, usb_se0);
      check_value("osc oe", 1, usb_oe);
      prev = usb_dp;
    end
    @(posedge clk_i);
    #1;
    wb_write(AddrCtrl, '0);
    wait_oe(1'b0);
    check_value("osc end dp", 1, usb_dp);
    check_value("osc end dn", 0, usb_dn);
    check_value("osc end d", 1, usb_d);
    model_en = 1'b1;

    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/usb_rx_model.sv
// Line monitor, samples one bit per BitDiv clocks on the falling clock edge
// Bit phase comes from the rising edge of oe, there is no clock recovery
// The bytes of the last packet stay in pkt_bytes until the next SE0
`timescale 1ns/1ps
`default_nettype none

module usb_rx_model import usb_tx_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic en_i,
  input  logic pinflip_i,
  input  logic oe_i,
  input  logic dp_i,
  input  logic dn_i,
  input  logic se0_i,
  output int   pkt_cnt_o,
  output logic run_err_o,
  output logic stuff_err_o,
  output logic align_err_o,
  output logic se0_err_o
);

  usb_byte_t pkt_bytes[$];
  usb_byte_t cur_bytes[$];
  usb_byte_t sr;
  logic      active, in_eop, prev_lvl;
  int        div, ones, run, nbits;

  initial begin
    pkt_cnt_o   = 0;
    run_err_o   = 1'b0;
    stuff_err_o = 1'b0;
    align_err_o = 1'b0;
    se0_err_o   = 1'b0;
    active      = 1'b0;
  end

  // One bit time on the line
  task automatic take_sample();
    logic lvl;
    logic bit_v;
    // The se0 pin must agree with both lines low
    if ((!dp_i && !dn_i) != se0_i) begin
      se0_err_o = 1'b1;
    end
    if (!dp_i && !dn_i) begin
      if (!in_eop) begin
        if (nbits != 0) begin
          align_err_o = 1'b1;
        end
        pkt_bytes = cur_bytes;
        pkt_cnt_o++;
        in_eop = 1'b1;
      end
    end else if (!in_eop) begin
      // J reads as 1 in either pin polarity
      lvl   = dp_i ^ pinflip_i;
      bit_v = (lvl == prev_lvl);
      // Seven bit times without a transition mean a missing stuffed zero
      run   = (lvl == prev_lvl) ? run + 1 : 0;
      if (run >= 7) begin
        run_err_o = 1'b1;
      end
      prev_lvl = lvl;
      if (ones == 6) begin
        // Stuffed bit must be a zero and is dropped
        if (bit_v) begin
          stuff_err_o = 1'b1;
        end
        ones = 0;
      end else begin
        sr    = {bit_v, sr[7:1]};
        nbits = nbits + 1;
        ones  = bit_v ? ones + 1 : 0;
        if (nbits == 8) begin
          cur_bytes.push_back(sr);
          nbits = 0;
        end
      end
    end
  endtask

  always @(negedge clk_i) begin
    if (!rst_ni || !en_i) begin
      active = 1'b0;
    end else if (active) begin
      if (div == BitDiv - 1) begin
        div = 0;
        if (!oe_i) begin
          active = 1'b0;
        end else begin
          take_sample();
        end
      end else begin
        div = div + 1;
      end
    end else if (oe_i) begin
      active   = 1'b1;
      div      = 0;
      in_eop   = 1'b0;
      prev_lvl = 1'b1;
      ones     = 0;
      run      = 0;
      nbits    = 0;
      cur_bytes.delete();
      take_sample();
    end
  end

endmodule

`default_nettype wire

// File: verilog/usb_tx_top.sv
// USB full-speed transmitter with a Wishbone classic register port
// Expects a 48 MHz clock, pins idle at J unless the pin flip is set
`timescale 1ns/1ps
`default_nettype none

module usb_tx_top import usb_tx_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     wb_cyc_i,
  input  logic     wb_stb_i,
  input  logic     wb_we_i,
  input  wb_addr_t wb_adr_i,
  input  wb_data_t wb_dat_i,
  output wb_data_t wb_dat_o,
  output logic     wb_ack_o,
  output logic     usb_oe_o,
  output logic     usb_d_o,
  output logic     usb_se0_o,
  output logic     usb_dp_o,
  output logic     usb_dn_o
);

  logic      fifo_full;
  logic      fifo_push;
  usb_byte_t fifo_wdata;
  logic      bit_strobe;
  logic      link_reset;
  logic      osc_test;
  logic      pinflip;

  usb_tx_pkt_if pkt_if ();

  usb_tx_csr u_csr (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .fifo_full_i  (fifo_full),
    .fifo_push_o  (fifo_push),
    .fifo_wdata_o (fifo_wdata),
    .bit_strobe_o (bit_strobe),
    .link_reset_o (link_reset),
    .osc_test_o   (osc_test),
    .pinflip_o    (pinflip),
    .pkt          (pkt_if.csr)
  );

  usb_tx_fifo u_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .link_reset_i (link_reset),
    .push_i       (fifo_push),
    .wdata_i      (fifo_wdata),
    .full_o       (fifo_full),
    .pkt          (pkt_if.fifo)
  );

  usb_fs_tx u_tx (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .link_reset_i       (link_reset),
    .cfg_pinflip_i      (pinflip),
    .tx_osc_test_mode_i (osc_test),
    .bit_strobe_i       (bit_strobe),
    .usb_oe_o           (usb_oe_o),
    .usb_d_o            (usb_d_o),
    .usb_se0_o          (usb_se0_o),
    .usb_dp_o           (usb_dp_o),
    .usb_dn_o           (usb_dn_o),
    .pkt                (pkt_if.tx)
  );

endmodule

`default_nettype wire

// File: verilog/usb_fs_tx.sv
// Full-speed packet serializer: SYNC, PID, payload, CRC16, EOP
// Needs at least two clocks per bit strobe, byte loads sit between strobes
// Token PIDs carry no CRC5 here, EOP follows the PID directly
`timescale 1ns/1ps
`default_nettype none

module usb_fs_tx import usb_tx_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic link_reset_i,
  input  logic cfg_pinflip_i,
  input  logic tx_osc_test_mode_i,
  input  logic bit_strobe_i,
  output logic usb_oe_o,
  output logic usb_d_o,
  output logic usb_se0_o,
  output logic usb_dp_o,
  output logic usb_dn_o,
  usb_tx_pkt_if.tx pkt
);

  typedef enum logic [2:0] {Idle, Sync, Pid, DataOrCrc0, Crc1, Eop, OscTest} state_e;
  typedef enum logic [1:0] {OsIdle, OsWaitByte, OsTransmit} out_state_e;

  state_e     state_q, state_d;
  out_state_e out_state_q, out_state_d;

  usb_pid_t   pid_q;
  usb_byte_t  data_sr_q, data_sr_d;
  logic [7:0] oe_sr_q, oe_sr_d;
  logic [7:0] se0_sr_q, se0_sr_d;
  logic [4:0] bit_hist_q, bit_hist_d;
  logic [5:0] bit_hist;
  logic [2:0] bit_cnt_q, bit_cnt_d;
  logic       byte_strobe_q, byte_strobe_d;
  logic       payload_q, payload_d;
  logic       data_get_q, data_get_d;
  logic       stuffed_q;
  logic       bitstuff, load, test_mode_start;
  logic [15:0] crc16_q, crc16_d;
  logic       crc_fb;

  logic       ser_data, ser_oe, ser_se0;
  logic       nrzi_en;
  logic       oe_q, oe_d;
  logic       usb_d_q, usb_d_d;
  logic       se0_q, se0_d;
  logic [2:0] eop_q, eop_d;
  logic       dp_next, dn_next, se0_next;

  function automatic usb_byte_t rev8(input usb_byte_t b);
    usb_byte_t r;
    for (int i = 0; i < 8; i++) begin
      r[i] = b[7 - i];
    end
    return r;
  endfunction

  always_ff @(posedge clk_i) begin
    if (pkt.pkt_start) begin
      pid_q <= pkt.pid;
    end
  end

  assign ser_data = data_sr_q[0];
  assign ser_oe   = oe_sr_q[0];
  assign ser_se0  = se0_sr_q[0];

  // Six ones in a row including the bit on the line now
  assign bit_hist = {ser_data, bit_hist_q};
  assign bitstuff = &bit_hist;

  // Strobe of the last EOP bit
  assign pkt.pkt_end  = bit_strobe_i && (se0_sr_q[1:0] == 2'b01);
  assign pkt.data_get = data_get_q;

  ////////////////////////////////////////////////////////////
  // Byte level FSM and shifter
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    data_sr_d       = data_sr_q;
    oe_sr_d         = oe_sr_q;
    se0_sr_d        = se0_sr_q;
    payload_d       = payload_q;
    data_get_d      = 1'b0;
    bit_hist_d      = bit_hist_q;
    bit_cnt_d       = bit_cnt_q;
    load            = 1'b0;
    test_mode_start = 1'b0;

    unique case (state_q)
      Idle: begin
        if (tx_osc_test_mode_i) begin
          state_d         = OscTest;
          test_mode_start = 1'b1;
        end else if (pkt.pkt_start) begin
          state_d = Sync;
        end
      end
      Sync: begin
        if (byte_strobe_q) begin
          state_d   = Pid;
          data_sr_d = 8'h80;
          load      = 1'b1;
        end
      end
      Pid: begin
        if (byte_strobe_q) begin
          // DATA0 and DATA1 have both low bits set
          state_d   = (pid_q[1:0] == 2'b11) ? DataOrCrc0 : Eop;
          data_sr_d = {~pid_q, pid_q};
          load      = 1'b1;
        end
      end
      DataOrCrc0: begin
        if (byte_strobe_q) begin
          load = 1'b1;
          if (pkt.data_avail) begin
            payload_d  = 1'b1;
            data_get_d = 1'b1;
            data_sr_d  = pkt.data;
          end else begin
            state_d   = Crc1;
            payload_d = 1'b0;
            data_sr_d = ~rev8(crc16_q[15:8]);
          end
        end
      end
      Crc1: begin
        if (byte_strobe_q) begin
          state_d   = Eop;
          data_sr_d = ~rev8(crc16_q[7:0]);
          load      = 1'b1;
        end
      end
      Eop: begin
        if (byte_strobe_q) begin
          // SE0, SE0, J with the line still driven
          state_d  = Idle;
          oe_sr_d  = 8'h07;
          se0_sr_d = 8'h07;
        end
      end
      OscTest: begin
        if (byte_strobe_q) begin
          if (!tx_osc_test_mode_i) begin
            state_d = Idle;
            oe_sr_d = '0;
          end else begin
            // All zeros toggle the line every bit
            data_sr_d = '0;
            load      = 1'b1;
          end
        end
      end
      default: state_d = Idle;
    endcase

    if (load) begin
      oe_sr_d  = '1;
      se0_sr_d = '0;
    end

    if (pkt.pkt_start) begin
      // Short gap before SYNC, counter wraps to zero after one bit
      bit_cnt_d  = 3'd7;
      bit_hist_d = '0;
    end else if (bit_strobe_i) begin
      bit_hist_d = bit_hist[5:1];
      if (bitstuff) begin
        // Hold the shifters and put a zero on the line next
        data_sr_d[0] = 1'b0;
      end else begin
        bit_cnt_d = bit_cnt_q + 1'b1;
        data_sr_d = data_sr_q >> 1;
        oe_sr_d   = oe_sr_q >> 1;
        se0_sr_d  = se0_sr_q >> 1;
      end
    end
  end

  assign byte_strobe_d = bit_strobe_i & ~bitstuff & ~pkt.pkt_start & (bit_cnt_q == 3'd0);

  // CRC16 over payload bits only, stuffed zeros skipped
  assign crc_fb = ser_data ^ crc16_q[15];

  always_comb begin
    crc16_d = crc16_q;
    if (pkt.pkt_start) begin
      crc16_d = '1;
    end else if (bit_strobe_i && payload_q && !stuffed_q) begin
      crc16_d = {crc16_q[14:0], 1'b0} ^ ({16{crc_fb}} & 16'h8005);
    end
  end

  always_ff @(posedge clk_i) begin
    crc16_q <= crc16_d;
  end

  ////////////////////////////////////////////////////////////
  // NRZI and line driver
  ////////////////////////////////////////////////////////////

  always_comb begin
    out_state_d = out_state_q;
    nrzi_en     = 1'b0;
    unique case (out_state_q)
      OsIdle: begin
        if (pkt.pkt_start || test_mode_start) begin
          out_state_d = OsWaitByte;
        end
      end
      OsWaitByte: begin
        if (byte_strobe_q) begin
          out_state_d = OsTransmit;
        end
      end
      OsTransmit: begin
        nrzi_en = 1'b1;
        // A new packet may start while the final J is still out
        if (pkt.pkt_start) begin
          out_state_d = OsWaitByte;
        end else if (bit_strobe_i && !ser_oe) begin
          out_state_d = OsIdle;
        end
      end
      default: out_state_d = OsIdle;
    endcase
  end

  always_comb begin
    usb_d_d = usb_d_q;
    se0_d   = se0_q;
    oe_d    = oe_q;
    eop_d   = eop_q;
    if (pkt.pkt_start) begin
      // Start from J so the first SYNC bit is K
      usb_d_d = 1'b1;
      eop_d   = 3'b100;
    end else if (bit_strobe_i && nrzi_en) begin
      oe_d = ser_oe;
      if (ser_se0) begin
        eop_d = eop_q >> 1;
        if (eop_q[0]) begin
          usb_d_d = 1'b1;
          se0_d   = 1'b0;
        end else begin
          se0_d = 1'b1;
        end
      end else if (!ser_data) begin
        usb_d_d = ~usb_d_q;
      end
      // Park at J when the driver lets go
      if (!oe_d) begin
        usb_d_d = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= Idle;
      out_state_q   <= OsIdle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      bit_hist_q    <= '0;
      bit_cnt_q     <= '0;
      byte_strobe_q <= 1'b0;
      payload_q     <= 1'b0;
      data_get_q    <= 1'b0;
      stuffed_q     <= 1'b0;
      oe_q          <= 1'b0;
      usb_d_q       <= 1'b1;
      se0_q         <= 1'b0;
      eop_q         <= '0;
    end else if (link_reset_i) begin
      state_q       <= Idle;
      out_state_q   <= OsIdle;
      data_sr_q     <= '0;
      oe_sr_q       <= '0;
      se0_sr_q      <= '0;
      bit_hist_q    <= '0;
      bit_cnt_q     <= '0;
      byte_strobe_q <= 1'b0;
      payload_q     <= 1'b0;
      data_get_q    <= 1'b0;
      stuffed_q     <= 1'b0;
      oe_q          <= 1'b0;
      usb_d_q       <= 1'b1;
      se0_q         <= 1'b0;
      eop_q         <= '0;
    end else begin
      state_q       <= state_d;
      out_state_q   <= out_state_d;
      data_sr_q     <= data_sr_d;
      oe_sr_q       <= oe_sr_d;
      se0_sr_q      <= se0_sr_d;
      bit_hist_q    <= bit_hist_d;
      bit_cnt_q     <= bit_cnt_d;
      byte_strobe_q <= byte_strobe_d;
      payload_q     <= payload_d;
      data_get_q    <= data_get_d;
      if (bit_strobe_i) begin
        // Marks the bit now on the line as a stuffed zero
        stuffed_q <= bitstuff;
      end
      oe_q          <= oe_d;
      usb_d_q       <= usb_d_d;
      se0_q         <= se0_d;
      eop_q         <= eop_d;
    end
  end

  // Pin flip swaps dp and dn, d mirrors dp
  always_comb begin
    if (link_reset_i) begin
      se0_next = 1'b0;
      dp_next  = ~cfg_pinflip_i;
      dn_next  = cfg_pinflip_i;
    end else begin
      se0_next = se0_q;
      dp_next  = (usb_d_q ^ cfg_pinflip_i) & ~se0_q;
      dn_next  = (~usb_d_q ^ cfg_pinflip_i) & ~se0_q;
    end
  end

  // Pins lag the NRZI state by one clock
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      usb_oe_o  <= 1'b0;
      usb_d_o   <= 1'b1;
      usb_se0_o <= 1'b0;
      usb_dp_o  <= 1'b1;
      usb_dn_o  <= 1'b0;
    end else begin
      usb_oe_o  <= oe_q & ~link_reset_i;
      usb_d_o   <= dp_next;
      usb_se0_o <= se0_next;
      usb_dp_o  <= dp_next;
      usb_dn_o  <= dn_next;
    end
  end

endmodule

`default_nettype wire

// File: verilog/usb_tx_fifo.sv
// Circular byte buffer, a push while full is dropped without notice here
// Pop removes the head in the cycle data_get is high, link reset flushes it
`timescale 1ns/1ps
`default_nettype none

module usb_tx_fifo import usb_tx_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      link_reset_i,
  input  logic      push_i,
  input  usb_byte_t wdata_i,
  output logic      full_o,
  usb_tx_pkt_if.fifo pkt
);

  usb_byte_t           mem_q [FifoDepth];
  logic [FifoPtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [FifoCntW-1:0] count_q;
  logic                push, pop;

  assign full_o = (count_q == FifoCntW'(FifoDepth));
  assign push   = push_i & ~full_o;
  assign pop    = pkt.data_get & pkt.data_avail;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (link_reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      // Pointers wrap naturally at the power of two depth
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign pkt.data_avail = (count_q != '0);
  assign pkt.data       = mem_q[rd_ptr_q];

endmodule

`default_nettype wire

// File: verilog/usb_tx_csr.sv
// Wishbone classic slave, every request is acknowledged one cycle after it is seen
// Writes to a full FIFO are acknowledged and dropped, the overflow flag records them
// A PID write is ignored while busy, in oscillator test or in link reset
`timescale 1ns/1ps
`default_nettype none

module usb_tx_csr import usb_tx_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      wb_cyc_i,
  input  logic      wb_stb_i,
  input  logic      wb_we_i,
  input  wb_addr_t  wb_adr_i,
  input  wb_data_t  wb_dat_i,
  output wb_data_t  wb_dat_o,
  output logic      wb_ack_o,
  input  logic      fifo_full_i,
  output logic      fifo_push_o,
  output usb_byte_t fifo_wdata_o,
  output logic      bit_strobe_o,
  output logic      link_reset_o,
  output logic      osc_test_o,
  output logic      pinflip_o,
  usb_tx_pkt_if.csr pkt
);

  logic     req, wr_req, rd_req;
  logic     ctrl_wr, pid_wr, pid_ok, data_wr, status_rd;
  logic     ack_q;
  logic     osc_test_q, pinflip_q, link_reset_q;
  logic     busy_q, done_q, ovf_q;
  logic     start_q, pkt_start_q;
  usb_pid_t pid_q;
  wb_data_t rdata, rdata_q;
  logic [BitDivW-1:0] div_q;

  ////////////////////////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////////////////////////

  // No new request is taken in the acknowledge cycle
  assign req       = wb_cyc_i & wb_stb_i & ~ack_q;
  assign wr_req    = req & wb_we_i;
  assign rd_req    = req & ~wb_we_i;
  assign ctrl_wr   = wr_req & (wb_adr_i == AddrCtrl);
  assign pid_wr    = wr_req & (wb_adr_i == AddrPid);
  assign data_wr   = wr_req & (wb_adr_i == AddrData);
  assign status_rd = rd_req & (wb_adr_i == AddrStatus);
  assign pid_ok    = pid_wr & ~busy_q & ~link_reset_q & ~osc_test_q;

  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      AddrCtrl: begin
        rdata[CtrlOscTest] = osc_test_q;
        rdata[CtrlPinFlip] = pinflip_q;
        rdata[CtrlLinkRst] = link_reset_q;
      end
      AddrPid: rdata[$bits(usb_pid_t)-1:0] = pid_q;
      AddrStatus: begin
        rdata[StBusy]  = busy_q;
        rdata[StFull]  = fifo_full_i;
        rdata[StEmpty] = ~pkt.data_avail;
        rdata[StDone]  = done_q;
        rdata[StOvf]   = ovf_q;
      end
      // Data register is write only
      default: rdata = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rdata_q <= rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers and flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q        <= 1'b0;
      osc_test_q   <= 1'b0;
      pinflip_q    <= 1'b0;
      link_reset_q <= 1'b0;
      pid_q        <= '0;
      start_q      <= 1'b0;
      pkt_start_q  <= 1'b0;
      busy_q       <= 1'b0;
      done_q       <= 1'b0;
      ovf_q        <= 1'b0;
    end else begin
      ack_q <= req;
      if (ctrl_wr) begin
        osc_test_q   <= wb_dat_i[CtrlOscTest];
        pinflip_q    <= wb_dat_i[CtrlPinFlip];
        link_reset_q <= wb_dat_i[CtrlLinkRst];
      end
      if (pid_ok) begin
        pid_q <= wb_dat_i[$bits(usb_pid_t)-1:0];
      end
      // Accepted in the ack cycle, start goes out one cycle later
      start_q     <= pid_ok;
      pkt_start_q <= start_q;
      if (pid_ok) begin
        busy_q <= 1'b1;
      end else if (pkt.pkt_end || link_reset_q) begin
        busy_q <= 1'b0;
      end
      // Setting wins over the clear of a status read in the same cycle
      if (pkt.pkt_end) begin
        done_q <= 1'b1;
      end else if (status_rd) begin
        done_q <= 1'b0;
      end
      if (data_wr && fifo_full_i) begin
        ovf_q <= 1'b1;
      end else if (status_rd) begin
        ovf_q <= 1'b0;
      end
    end
  end

  // Free-running bit time divider
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      div_q <= '0;
    end else if (div_q == BitDivW'(BitDiv - 1)) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  assign bit_strobe_o  = (div_q == BitDivW'(BitDiv - 1));
  assign wb_ack_o      = ack_q;
  assign wb_dat_o      = rdata_q;
  assign fifo_push_o   = data_wr;
  assign fifo_wdata_o  = wb_dat_i[$bits(usb_byte_t)-1:0];
  assign link_reset_o  = link_reset_q;
  assign osc_test_o    = osc_test_q;
  assign pinflip_o     = pinflip_q;
  assign pkt.pkt_start = pkt_start_q;
  assign pkt.pid       = pid_q;

endmodule

`default_nettype wire

// File: verilog/usb_tx_pkt_if.sv
// Packet side link between register block, byte FIFO and serializer
// pkt_start and data_get are single-cycle pulses, data_avail is a level
`timescale 1ns/1ps
`default_nettype none

interface usb_tx_pkt_if import usb_tx_pkg::*; ();

  logic      pkt_start;
  usb_pid_t  pid;
  logic      pkt_end;
  logic      data_avail;
  usb_byte_t data;
  logic      data_get;

  modport csr (output pkt_start, output pid, input pkt_end, input data_avail);

  modport fifo (output data_avail, output data, input data_get);

  modport tx (
    input  pkt_start,
    input  pid,
    output pkt_end,
    input  data_avail,
    input  data,
    output data_get
  );

endinterface

`default_nettype wire

// File: verilog/usb_tx_pkg.sv
// Shared widths, register map and sizes of the USB full-speed transmitter
// FifoDepth must stay a power of two, the FIFO pointers wrap on their own
// BitDiv assumes a 48 MHz clock for the 12 Mbit/s line rate
`default_nettype none

package usb_tx_pkg;

  typedef logic [7:0]  usb_byte_t;
  typedef logic [3:0]  usb_pid_t;
  typedef logic [1:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;

  // Byte FIFO between bus and serializer
  localparam int unsigned FifoDepth = 8;
  localparam int unsigned FifoPtrW  = $clog2(FifoDepth);
  localparam int unsigned FifoCntW  = FifoPtrW + 1;

  // Clock cycles per bit time
  localparam int unsigned BitDiv  = 4;
  localparam int unsigned BitDivW = $clog2(BitDiv);

  // Register word addresses
  localparam wb_addr_t AddrCtrl   = 2'd0;
  localparam wb_addr_t AddrPid    = 2'd1;
  localparam wb_addr_t AddrData   = 2'd2;
  localparam wb_addr_t AddrStatus = 2'd3;

  // Control register bits
  localparam int unsigned CtrlOscTest = 0;
  localparam int unsigned CtrlPinFlip = 1;
  localparam int unsigned CtrlLinkRst = 2;

  // Status register bits, done and overflow clear on read
  localparam int unsigned StBusy  = 0;
  localparam int unsigned StFull  = 1;
  localparam int unsigned StEmpty = 2;
  localparam int unsigned StDone  = 3;
  localparam int unsigned StOvf   = 4;

endpackage

`default_nettype wire
